// ==== logic/sensor_cmd_pkg.sv ====
// ----------------------------------------------------------
// sensor command package
// command bus widths, channel register map and opcodes
// ----------------------------------------------------------
`default_nettype none

package sensor_cmd_pkg;

    localparam int CMD_BYTE_W = 8;   // one byte on the command bus
    localparam int CMD_DATA_W = 16;  // data low + data high
    localparam int CMD_ADDR_W = 16;  // address low + address high

    // register offsets inside one channel window
    localparam int SENS_REL_MODE   = 0;  // data[0] enables the channel
    localparam int SENS_REL_LATE   = 1;  // lines from sof to sof_late
    localparam int SENS_REL_HEIGHT = 2;  // lines per frame
    localparam int SENS_REL_STATUS = 3;  // status request, data[5:0] is seq

    // decoded register operation
    typedef enum logic [1:0] {
        CMD_MODE,
        CMD_LATE,
        CMD_HEIGHT,
        CMD_STATUS
    } cmd_op_e;

    localparam int NUM_CHN = 4;  // sensor channels in the group
    localparam int CHN_W   = 2;  // channel index bits

endpackage

`default_nettype wire

// ==== logic/sensor_frame_pkg.sv ====
// ----------------------------------------------------------
// sensor frame package
// frame sync state, counter widths and status packet length
// ----------------------------------------------------------
`default_nettype none

package sensor_frame_pkg;

    localparam int LINE_W  = 16;  // line counter and line registers
    localparam int FRAME_W = 8;   // frame counter, reported in status byte 1

    // per-channel frame state
    typedef enum logic {
        FS_IDLE,    // waiting for vsync
        FS_ACTIVE   // counting line ends
    } frame_state_e;

    // packet: {chn, seq}, frame count, {en, active, late[5:0]}
    localparam int STATUS_BYTES = 3;

    localparam int FRAME_LINES_DFLT = 16;  // frame height out of reset

endpackage

`default_nettype wire

// ==== logic/sensor_cmd_decoder.sv ====
// ----------------------------------------------------------
// sensor command decoder
// collects byte-serial commands, writes channel registers
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module sensor_cmd_decoder #(
    parameter int SENSOR_GROUP_ADDR = 'h400,  // first address of the group
    parameter int SENSOR_BASE_INC   = 'h040   // step between channel windows
) (
    input  logic                                  mclk,
    input  logic                                  rst,
    input  logic [sensor_cmd_pkg::CMD_BYTE_W-1:0] cmd_ad,    // AL, AH, DL, DH
    input  logic                                  cmd_stb,   // with AL only
    output logic [sensor_cmd_pkg::NUM_CHN-1:0]    cmd_wr,    // one-hot, one cycle
    output sensor_cmd_pkg::cmd_op_e               cmd_op,
    output logic [sensor_cmd_pkg::CMD_DATA_W-1:0] cmd_data
);
    import sensor_cmd_pkg::*;

    localparam int GRP_SPAN = NUM_CHN * SENSOR_BASE_INC;  // whole group window

    logic [CMD_BYTE_W-1:0] cmd_ad_r;   // bus byte, registered once
    logic                  cmd_stb_r;
    logic                  busy;       // command in progress
    logic [1:0]            byte_cnt;   // index of the byte in cmd_ad_r
    logic [CMD_ADDR_W-1:0] cmd_addr;
    logic [CMD_BYTE_W-1:0] data_lo;
    logic                  last_byte;  // data high in cmd_ad_r
    int                    addr_rel;
    int                    addr_off;
    logic [CHN_W-1:0]      chn_idx;
    logic                  in_grp;
    logic                  off_ok;
    cmd_op_e               op_dec;

    always_ff @(posedge mclk) begin
        cmd_ad_r <= cmd_ad;
        if (rst) cmd_stb_r <= 1'b0;
        else     cmd_stb_r <= cmd_stb;
    end

    // byte counter, restarted by every strobe
    always_ff @(posedge mclk) begin
        if (rst) begin
            busy     <= 1'b0;
            byte_cnt <= 2'd0;
        end else if (cmd_stb_r) begin
            busy     <= 1'b1;
            byte_cnt <= 2'd1;               // next byte is address high
        end else if (busy) begin
            byte_cnt <= byte_cnt + 2'd1;    // wraps to 0 after data high
            if (byte_cnt == 2'd3) busy <= 1'b0;
        end
    end

    always_ff @(posedge mclk) begin
        if (cmd_stb_r)                  cmd_addr[CMD_BYTE_W-1:0]          <= cmd_ad_r;
        if (busy && byte_cnt == 2'd1)   cmd_addr[CMD_ADDR_W-1:CMD_BYTE_W] <= cmd_ad_r;
        if (busy && byte_cnt == 2'd2)   data_lo                           <= cmd_ad_r;
    end

    assign last_byte = busy && (byte_cnt == 2'd3);

    // group window, channel and offset inside the channel window
    always_comb begin
        addr_rel = int'(cmd_addr) - SENSOR_GROUP_ADDR;
        in_grp   = (addr_rel >= 0) && (addr_rel < GRP_SPAN);
        chn_idx  = CHN_W'(addr_rel / SENSOR_BASE_INC);
        addr_off = addr_rel % SENSOR_BASE_INC;
    end

    always_comb begin
        op_dec = CMD_MODE;
        off_ok = 1'b1;
        case (addr_off)
            SENS_REL_MODE:   op_dec = CMD_MODE;
            SENS_REL_LATE:   op_dec = CMD_LATE;
            SENS_REL_HEIGHT: op_dec = CMD_HEIGHT;
            SENS_REL_STATUS: op_dec = CMD_STATUS;
            default:         off_ok = 1'b0;      // hole in the window, dropped
        endcase
    end

    always_ff @(posedge mclk) begin
        if (rst)                                cmd_wr <= '0;
        else if (last_byte && in_grp && off_ok) cmd_wr <= NUM_CHN'(1) << chn_idx;
        else                                    cmd_wr <= '0;
    end

    always_ff @(posedge mclk) begin
        if (last_byte) begin
            cmd_op   <= op_dec;
            cmd_data <= {cmd_ad_r, data_lo};    // data high is on the bus now
        end
    end

endmodule

`default_nettype wire

// ==== logic/sensor_frame_sync.sv ====
// ----------------------------------------------------------
// sensor frame sync, one channel
// frame pulses from vsync/hsync, registers, status packet
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module sensor_frame_sync #(
    parameter int CHN_NUM        = 0,   // channel number for status byte 0
    parameter int SYNC_LATE_DFLT = 15   // late line count out of reset
) (
    input  logic                                  mclk,
    input  logic                                  rst,
    input  logic                                  cmd_wr,     // write to this channel
    input  sensor_cmd_pkg::cmd_op_e               cmd_op,
    input  logic [sensor_cmd_pkg::CMD_DATA_W-1:0] cmd_data,
    input  logic                                  sns_vsync,  // frame start pulse
    input  logic                                  sns_hsync,  // line end pulse
    input  logic                                  stat_take,  // stat_ad consumed
    output logic                                  sof_out,
    output logic                                  sof_late,
    output logic                                  eof_out,
    output logic                                  stat_rq,
    output logic [sensor_cmd_pkg::CMD_BYTE_W-1:0] stat_ad
);
    import sensor_cmd_pkg::*;
    import sensor_frame_pkg::*;

    localparam int IDX_W = $clog2(STATUS_BYTES);

    logic               enable;
    logic [LINE_W-1:0]  late_lines;
    logic [LINE_W-1:0]  height;
    frame_state_e       state;
    logic [LINE_W-1:0]  line_cnt;    // line ends seen in this frame
    logic [LINE_W-1:0]  line_next;
    logic               late_done;   // sof_late already sent this frame
    logic               frame_end;
    logic               late_fire;
    logic [FRAME_W-1:0] frame_cnt;
    logic [5:0]         seq;         // sequence number of the pending request
    logic               stat_req;
    logic [IDX_W-1:0]   stat_idx;    // packet byte on stat_ad

    always_ff @(posedge mclk) begin
        if (rst) begin
            enable     <= 1'b0;
            late_lines <= LINE_W'(SYNC_LATE_DFLT);
            height     <= LINE_W'(FRAME_LINES_DFLT);
        end else if (cmd_wr) begin
            case (cmd_op)
                CMD_MODE:   enable     <= cmd_data[0];
                CMD_LATE:   late_lines <= LINE_W'(cmd_data);
                CMD_HEIGHT: height     <= LINE_W'(cmd_data);
                default:    ;                              // status handled below
            endcase
        end
    end

    assign line_next = line_cnt + LINE_W'(1);
    assign frame_end = (line_next >= height);
    // late count past the height falls back to eof
    assign late_fire = !late_done && ((line_next >= late_lines) || frame_end);

    always_ff @(posedge mclk) begin
        if (rst) begin
            state     <= FS_IDLE;
            line_cnt  <= '0;
            late_done <= 1'b0;
            frame_cnt <= '0;
            sof_out   <= 1'b0;
            sof_late  <= 1'b0;
            eof_out   <= 1'b0;
        end else begin
            sof_out  <= 1'b0;
            sof_late <= 1'b0;
            eof_out  <= 1'b0;
            case (state)
                FS_IDLE: begin
                    if (sns_vsync && enable) begin
                        state     <= FS_ACTIVE;
                        line_cnt  <= '0;
                        late_done <= 1'b0;
                        sof_out   <= 1'b1;
                    end
                end
                FS_ACTIVE: begin
                    if (sns_hsync) begin
                        line_cnt <= line_next;
                        if (late_fire) begin
                            sof_late  <= 1'b1;
                            late_done <= 1'b1;
                        end
                        if (frame_end) begin
                            eof_out   <= 1'b1;
                            frame_cnt <= frame_cnt + FRAME_W'(1);
                            state     <= FS_IDLE;   // vsync ignored until here
                        end
                    end
                end
                default: state <= FS_IDLE;
            endcase
        end
    end

    assign stat_req = cmd_wr && (cmd_op == CMD_STATUS);

    always_ff @(posedge mclk) begin
        if (stat_req) seq <= cmd_data[5:0];   // newer request overrides seq
    end

    // one pending packet, bytes advance on each take
    always_ff @(posedge mclk) begin
        if (rst) begin
            stat_rq  <= 1'b0;
            stat_idx <= '0;
        end else begin
            if (stat_take) begin
                if (stat_idx == IDX_W'(STATUS_BYTES - 1)) begin
                    stat_rq  <= 1'b0;
                    stat_idx <= '0;
                end else begin
                    stat_idx <= stat_idx + IDX_W'(1);
                end
            end
            if (stat_req) stat_rq <= 1'b1;
        end
    end

    always_comb begin
        case (stat_idx)
            IDX_W'(0): stat_ad = {CHN_W'(CHN_NUM), seq};
            IDX_W'(1): stat_ad = CMD_BYTE_W'(frame_cnt);
            default:   stat_ad = {enable, state == FS_ACTIVE, late_lines[5:0]};
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/sensor_status_router.sv ====
// ----------------------------------------------------------
// sensor status router
// round-robin merge of channel packets under credit control
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module sensor_status_router #(
    parameter int STATUS_CREDITS = 2   // packets the receiver can buffer
) (
    input  logic                                                         mclk,
    input  logic                                                         rst,
    input  logic [sensor_cmd_pkg::NUM_CHN-1:0]                           stat_rq,
    input  logic [sensor_cmd_pkg::NUM_CHN-1:0][sensor_cmd_pkg::CMD_BYTE_W-1:0] stat_ad,
    input  logic                                                         status_credit,
    output logic [sensor_cmd_pkg::NUM_CHN-1:0]                           stat_take,
    output logic [sensor_cmd_pkg::CMD_BYTE_W-1:0]                        status_ad,
    output logic                                                         status_valid,
    output logic                                                         status_last
);
    import sensor_cmd_pkg::*;
    import sensor_frame_pkg::*;

    localparam int CRED_W = $clog2(STATUS_CREDITS + 1);
    localparam int BCNT_W = $clog2(STATUS_BYTES);

    logic [CRED_W-1:0] credit_cnt;
    logic [CHN_W-1:0]  rr_ptr;    // channel served last
    logic              busy;      // forwarding bytes 1 and up
    logic [CHN_W-1:0]  sel;       // channel being forwarded
    logic [BCNT_W-1:0] bcnt;      // byte index taken this cycle
    logic [CHN_W-1:0]  win;
    logic              win_vld;
    logic              grant;
    logic [CHN_W-1:0]  cur;

    // nearest requester after rr_ptr wins, rr_ptr itself last
    always_comb begin
        logic [CHN_W-1:0] cand;
        win     = rr_ptr;
        win_vld = 1'b0;
        for (int k = NUM_CHN; k >= 1; k--) begin
            cand = rr_ptr + CHN_W'(k);
            if (stat_rq[cand]) begin
                win     = cand;
                win_vld = 1'b1;
            end
        end
    end

    assign grant     = !busy && win_vld && (credit_cnt != '0);
    assign cur       = busy ? sel : win;
    assign stat_take = (busy || grant) ? (NUM_CHN'(1) << cur) : '0;

    always_ff @(posedge mclk) begin
        if (rst) begin
            credit_cnt   <= CRED_W'(STATUS_CREDITS);
            rr_ptr       <= CHN_W'(NUM_CHN - 1);       // channel 0 first
            busy         <= 1'b0;
            sel          <= '0;
            bcnt         <= '0;
            status_valid <= 1'b0;
            status_last  <= 1'b0;
        end else begin
            // one credit per packet, paid on byte 0
            credit_cnt   <= credit_cnt + CRED_W'(status_credit) - CRED_W'(grant);
            status_valid <= busy || grant;
            status_last  <= busy && (bcnt == BCNT_W'(STATUS_BYTES - 1));
            if (grant) begin
                busy   <= 1'b1;
                sel    <= win;
                rr_ptr <= win;
                bcnt   <= BCNT_W'(1);
            end else if (busy) begin
                if (bcnt == BCNT_W'(STATUS_BYTES - 1)) begin
                    busy <= 1'b0;
                    bcnt <= '0;
                end else begin
                    bcnt <= bcnt + BCNT_W'(1);
                end
            end
        end
    end

    always_ff @(posedge mclk) begin
        status_ad <= stat_ad[cur];    // qualified by status_valid
    end

endmodule

`default_nettype wire

// ==== logic/sensor_group.sv ====
// ----------------------------------------------------------
// sensor group top level
// command decoder, four channel frame syncs, status router
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module sensor_group #(
    parameter int SENSOR_GROUP_ADDR = 'h400,  // group base address
    parameter int SENSOR_BASE_INC   = 'h040,  // channel window size
    parameter int SYNC_LATE_DFLT    = 15,     // late sync lines after reset
    parameter int STATUS_CREDITS    = 2       // receiver packet credits
) (
    input  logic                                  mclk,
    input  logic                                  rst,
    input  logic [sensor_cmd_pkg::CMD_BYTE_W-1:0] cmd_ad,
    input  logic                                  cmd_stb,
    input  logic [sensor_cmd_pkg::NUM_CHN-1:0]    sns_vsync,
    input  logic [sensor_cmd_pkg::NUM_CHN-1:0]    sns_hsync,
    input  logic                                  status_credit,
    output logic [sensor_cmd_pkg::NUM_CHN-1:0]    sof_out,
    output logic [sensor_cmd_pkg::NUM_CHN-1:0]    sof_late,
    output logic [sensor_cmd_pkg::NUM_CHN-1:0]    eof_out,
    output logic [sensor_cmd_pkg::CMD_BYTE_W-1:0] status_ad,
    output logic                                  status_valid,
    output logic                                  status_last
);
    import sensor_cmd_pkg::*;

    logic [NUM_CHN-1:0]                 cmd_wr;     // per-channel write strobe
    cmd_op_e                            cmd_op;
    logic [CMD_DATA_W-1:0]              cmd_data;
    logic [NUM_CHN-1:0]                 stat_rq;
    logic [NUM_CHN-1:0][CMD_BYTE_W-1:0] stat_ad;
    logic [NUM_CHN-1:0]                 stat_take;

    sensor_cmd_decoder #(
        .SENSOR_GROUP_ADDR (SENSOR_GROUP_ADDR),
        .SENSOR_BASE_INC   (SENSOR_BASE_INC)
    ) cmd_decoder_inst (
        .mclk     (mclk),
        .rst      (rst),
        .cmd_ad   (cmd_ad),
        .cmd_stb  (cmd_stb),
        .cmd_wr   (cmd_wr),
        .cmd_op   (cmd_op),
        .cmd_data (cmd_data)
    );

    for (genvar i = 0; i < NUM_CHN; i++) begin : gen_chn
        sensor_frame_sync #(
            .CHN_NUM        (i),
            .SYNC_LATE_DFLT (SYNC_LATE_DFLT)
        ) frame_sync_inst (
            .mclk      (mclk),
            .rst       (rst),
            .cmd_wr    (cmd_wr[i]),
            .cmd_op    (cmd_op),
            .cmd_data  (cmd_data),
            .sns_vsync (sns_vsync[i]),
            .sns_hsync (sns_hsync[i]),
            .stat_take (stat_take[i]),
            .sof_out   (sof_out[i]),
            .sof_late  (sof_late[i]),
            .eof_out   (eof_out[i]),
            .stat_rq   (stat_rq[i]),
            .stat_ad   (stat_ad[i])
        );
    end

    sensor_status_router #(
        .STATUS_CREDITS (STATUS_CREDITS)
    ) status_router_inst (
        .mclk          (mclk),
        .rst           (rst),
        .stat_rq       (stat_rq),
        .stat_ad       (stat_ad),
        .status_credit (status_credit),
        .stat_take     (stat_take),
        .status_ad     (status_ad),
        .status_valid  (status_valid),
        .status_last   (status_last)
    );

endmodule

`default_nettype wire

// ==== include/tb_sensor_group_cases.svh ====
// ----------------------------------------------------------
// sensor group testbench step table
// ----------------------------------------------------------
`ifndef TB_SENSOR_GROUP_CASES_SVH
`define TB_SENSOR_GROUP_CASES_SVH

localparam int NUM_STEPS = 18;

// kind, chn, data, lines, exp sof, exp sof_late, exp eof
int steps [NUM_STEPS][7] = '{
    '{K_IDLE,   0, 'h00, 20, 0, 0, 0},   // quiet after reset
    '{K_FRAME,  1, 'h00,  4, 0, 0, 0},   // disabled channel
    '{K_HEIGHT, 1, 'h06,  0, 0, 0, 0},
    '{K_LATE,   1, 'h03,  0, 0, 0, 0},
    '{K_MODE,   1, 'h01,  0, 0, 0, 0},
    '{K_FRAME,  1, 'h00,  6, 1, 1, 1},   // late before eof
    '{K_STAT,   1, 'h15,  0, 0, 0, 0},
    '{K_HEIGHT, 2, 'h05,  0, 0, 0, 0},
    '{K_LATE,   2, 'h09,  0, 0, 0, 0},
    '{K_MODE,   2, 'h01,  0, 0, 0, 0},
    '{K_BAD,    2, 'h01,  0, 0, 0, 0},   // outside the group
    '{K_FRAME,  2, 'h00,  5, 1, 1, 1},   // late falls on eof
    '{K_STAT,   2, 'h2a,  0, 0, 0, 0},
    '{K_MODE,   0, 'h01,  0, 0, 0, 0},
    '{K_FRAME,  0, 'h00, 16, 1, 1, 1},   // reset height and late
    '{K_LIVE,   0, 'h07,  0, 0, 0, 0},   // status taken inside a frame
    '{K_BURST,  0, 'h30,  0, 0, 0, 0},   // all four under two credits
    '{K_STAT,   0, 'h3f,  0, 0, 0, 0}
};

`endif

// ==== sim/tb_sensor_group.sv ====
// ----------------------------------------------------------
// sensor group testbench
// table-driven commands, frames and status packet checks
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_sensor_group;

    localparam int K_MODE   = 0;
    localparam int K_LATE   = 1;
    localparam int K_HEIGHT = 2;
    localparam int K_STAT   = 3;
    localparam int K_FRAME  = 4;
    localparam int K_BAD    = 5;
    localparam int K_BURST  = 6;
    localparam int K_IDLE   = 7;
    localparam int K_LIVE   = 8;
    localparam int GROUP_ADDR = 'h400;
    localparam int BASE_INC   = 'h040;
    localparam int STEP_MAX   = 300;   // cycles, longest step with margin

    `include "tb_sensor_group_cases.svh"

    localparam int CYCLE_LIMIT = NUM_STEPS * STEP_MAX + 100;

    logic       mclk;
    logic       rst;
    logic [7:0] cmd_ad;
    logic       cmd_stb;
    logic [3:0] sns_vsync;
    logic [3:0] sns_hsync;
    logic       status_credit;
    logic [3:0] sof_out;
    logic [3:0] sof_late;
    logic [3:0] eof_out;
    logic [7:0] status_ad;
    logic       status_valid;
    logic       status_last;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic [23:0] pkt_q[$];     // packets seen on the status output
    logic [23:0] exp_q[$];
    logic [23:0] pkt_cur;
    int          bidx = 0;
    // reference model state
    int m_en[4];
    int m_late[4];
    int m_h[4];
    int m_fc[4];
    int m_last = 3;            // channel 0 first after reset
    int m_cred = 2;
    // frame step results
    int f_sof;
    int f_late;
    int f_eof;
    int late_at;
    int eof_at;

    sensor_group sensor_group_inst (
        .mclk          (mclk),
        .rst           (rst),
        .cmd_ad        (cmd_ad),
        .cmd_stb       (cmd_stb),
        .sns_vsync     (sns_vsync),
        .sns_hsync     (sns_hsync),
        .status_credit (status_credit),
        .sof_out       (sof_out),
        .sof_late      (sof_late),
        .eof_out       (eof_out),
        .status_ad     (status_ad),
        .status_valid  (status_valid),
        .status_last   (status_last)
    );

    initial begin
        mclk = 1'b0;
        forever #2 mclk = ~mclk;   // 4 ns period
    end

    always @(posedge mclk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // packet collector on the falling edge
    always @(negedge mclk) begin
        if (!rst) begin
            if (status_valid) begin
                pkt_cur = {pkt_cur[15:0], status_ad};
                assert (status_last == (bidx == 2)) else begin
                    errors++;
                    $display("FAIL status_last: got 0x%0h expected 0x%0h",
                             status_last, (bidx == 2));
                end
                if (bidx == 2) begin
                    pkt_q.push_back(pkt_cur);
                    bidx = 0;
                end else begin
                    bidx++;
                end
            end else if (bidx != 0) begin
                errors++;
                $display("status packet bytes were not contiguous");
                bidx = 0;
            end
        end
    end

    task automatic check_val(input string name, input int got, input int expv);
        checks++;
        assert (got == expv) else begin
            errors++;
            $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, expv);
        end
    endtask

    function automatic int chn_addr(input int c, input int off);
        return GROUP_ADDR + c * BASE_INC + off;
    endfunction

    function automatic logic [23:0] packet_of(input int c, input int seq, input logic act);
        return {c[1:0], seq[5:0], m_fc[c][7:0], m_en[c][0], act, m_late[c][5:0]};
    endfunction

    // next requester after the channel served last
    function automatic int rr_next(input logic [3:0] mask, input int last);
        int c;
        for (int k = 1; k <= 4; k++) begin
            c = (last + k) % 4;
            if (mask[c]) return c;
        end
        return -1;
    endfunction

    task automatic send_cmd(input int addr, input int data);
        @(negedge mclk);
        cmd_stb = 1'b1;
        cmd_ad  = addr[7:0];
        @(negedge mclk);
        cmd_stb = 1'b0;
        cmd_ad  = addr[15:8];
        @(negedge mclk);
        cmd_ad  = data[7:0];
        @(negedge mclk);
        cmd_ad  = data[15:8];
        @(negedge mclk);
        cmd_ad  = 8'h00;
        repeat (3 + $urandom_range(0, 3)) @(negedge mclk);   // write lands in 2
    endtask

    task automatic sample(input int c, input int done);
        if (sof_out[c])  f_sof++;
        if (sof_late[c]) begin
            f_late++;
            late_at = done;
        end
        if (eof_out[c]) begin
            f_eof++;
            eof_at = done;
        end
    endtask

    task automatic play_frame(input int c, input int lines);
        int gap;
        f_sof   = 0;
        f_late  = 0;
        f_eof   = 0;
        late_at = -1;
        eof_at  = -1;
        @(negedge mclk);
        sample(c, 0);
        sns_vsync[c] = 1'b1;
        @(negedge mclk);
        sample(c, 0);
        sns_vsync[c] = 1'b0;
        for (int j = 1; j <= lines; j++) begin
            @(negedge mclk);
            sample(c, j - 1);
            sns_hsync[c] = 1'b1;
            @(negedge mclk);
            sample(c, j);
            sns_hsync[c] = 1'b0;
            gap = $urandom_range(0, 2);
            repeat (gap) begin
                @(negedge mclk);
                sample(c, j);
            end
        end
        repeat (4) begin
            @(negedge mclk);
            sample(c, lines);
        end
    endtask

    task automatic wait_pkts(input int n);
        while (pkt_q.size() < n) @(posedge mclk);
        repeat (20) @(posedge mclk);   // room for any extra packet
        check_val("packet count", pkt_q.size(), n);
    endtask

    task automatic compare_pkts();
        logic [23:0] got;
        logic [23:0] expv;
        while (exp_q.size() > 0 && pkt_q.size() > 0) begin
            got  = pkt_q.pop_front();
            expv = exp_q.pop_front();
            check_val("status packet", got, expv);
        end
        pkt_q.delete();
        exp_q.delete();
    endtask

    task automatic give_credit();
        @(negedge mclk);
        status_credit = 1'b1;
        @(negedge mclk);
        status_credit = 1'b0;
    endtask

    // status request between vsync and the last line end
    task automatic stat_in_frame(input int c, input int data);
        @(negedge mclk);
        sns_vsync[c] = 1'b1;
        @(negedge mclk);
        sns_vsync[c] = 1'b0;
        send_cmd(chn_addr(c, K_STAT), data);
        exp_q.push_back(packet_of(c, data, 1'b1));
        m_last = c;
        wait_pkts(1);
        compare_pkts();
        give_credit();
        repeat (m_h[c]) begin
            @(negedge mclk);
            sns_hsync[c] = 1'b1;
            @(negedge mclk);
            sns_hsync[c] = 1'b0;
        end
        m_fc[c]++;
        repeat (2) @(negedge mclk);   // eof drains
    endtask

    task automatic run_burst(input int data);
        logic [3:0] mask;
        int         seqs[4];
        int         c;
        int         g;
        mask = '0;
        for (int i = 0; i < 4; i++) begin
            c       = 3 - i;   // reverse order makes round-robin visible
            seqs[c] = data + c;
            send_cmd(chn_addr(c, K_STAT), seqs[c]);
            mask[c] = 1'b1;
            if (m_cred > 0) begin
                g       = rr_next(mask, m_last);
                mask[g] = 1'b0;
                m_last  = g;
                m_cred--;
                exp_q.push_back(packet_of(g, seqs[g], 1'b0));
            end
        end
        wait_pkts(2);
        compare_pkts();
        while (mask != 0) begin
            give_credit();
            g       = rr_next(mask, m_last);
            mask[g] = 1'b0;
            m_last  = g;
            exp_q.push_back(packet_of(g, seqs[g], 1'b0));
            wait_pkts(1);
            compare_pkts();
        end
        give_credit();
        give_credit();
        m_cred = 2;
    endtask

    initial begin
        int kind;
        int c;
        int data;
        int lines;
        int quiet;
        void'($urandom(32'h4303_b453));
        rst = 1'b1;
        cmd_ad = 8'h00;
        cmd_stb = 1'b0;
        sns_vsync = '0;
        sns_hsync = '0;
        status_credit = 1'b0;
        for (int i = 0; i < 4; i++) begin
            m_en[i] = 0;
            m_late[i] = 15;
            m_h[i] = 16;
            m_fc[i] = 0;
        end
        repeat (8) @(negedge mclk);
        rst = 1'b0;
        for (int s = 0; s < NUM_STEPS; s++) begin
            kind  = steps[s][0];
            c     = steps[s][1];
            data  = steps[s][2];
            lines = steps[s][3];
            case (kind)
                K_MODE, K_LATE, K_HEIGHT: begin
                    send_cmd(chn_addr(c, kind), data);
                    if (kind == K_MODE)   m_en[c]   = data & 1;
                    if (kind == K_LATE)   m_late[c] = data;
                    if (kind == K_HEIGHT) m_h[c]    = data;
                end
                K_BAD: send_cmd(chn_addr(4, K_LATE), data);   // one past the group
                K_FRAME: begin
                    play_frame(c, lines);
                    check_val("sof_out count", f_sof, steps[s][4]);
                    check_val("sof_late count", f_late, steps[s][5]);
                    check_val("eof_out count", f_eof, steps[s][6]);
                    if (m_en[c] != 0 && lines >= m_h[c]) begin
                        check_val("sof_late line", late_at,
                                  (m_late[c] < m_h[c]) ? m_late[c] : m_h[c]);
                        check_val("eof_out line", eof_at, m_h[c]);
                        m_fc[c]++;
                    end
                end
                K_STAT: begin
                    send_cmd(chn_addr(c, K_STAT), data);
                    exp_q.push_back(packet_of(c, data, 1'b0));
                    m_last = c;
                    wait_pkts(1);
                    compare_pkts();
                    give_credit();
                end
                K_LIVE: stat_in_frame(c, data);
                K_BURST: run_burst(data);
                default: begin
                    quiet = 0;
                    repeat (lines) begin
                        @(negedge mclk);
                        quiet += (|sof_out) + (|sof_late) + (|eof_out) + status_valid;
                    end
                    check_val("outputs after reset", quiet, 0);
                end
            endcase
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sensor_group.f ====
+incdir+include
logic/sensor_cmd_pkg.sv
logic/sensor_frame_pkg.sv
logic/sensor_cmd_decoder.sv
logic/sensor_frame_sync.sv
logic/sensor_status_router.sv
logic/sensor_group.sv
sim/tb_sensor_group.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the sensor_group testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sensor_group.f \
    --top-module tb_sensor_group -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_sensor_group)
run_status=$?
echo "$out"
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi

if echo "$out" | grep -q "^Simulation passed$"; then
    exit 0
fi
exit 1
